// File: src/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// --------------------
// Memory sizing
// --------------------
`define SOC_RAM_ADDR_W 10                      // 1024 words
`define SOC_RAM_DEPTH (1 << `SOC_RAM_ADDR_W)

// --------------------
// UART timing
// --------------------
// Clocks per bit kept small so frames stay short in simulation
`define SOC_UART_DIVISOR 16

// --------------------
// Address map
// --------------------
`define SOC_REGION_RAM  4'h0                   // Compared against address[31:28]
`define SOC_REGION_GPIO 4'h1
`define SOC_REGION_UART 4'h2

`define SOC_REG_OFF0 1'b0                      // Register at byte offset 0x0
`define SOC_REG_OFF4 1'b1                      // Register at byte offset 0x4

`endif

// File: src/soc_pkg.sv
`include "soc_settings.svh"

package soc_pkg;

    // --------------------
    // Bus types
    // --------------------
    typedef logic [31:0] bus_word_t;           // Data word on the bus
    typedef logic [31:0] bus_addr_t;           // Byte address
    typedef logic [3:0]  byte_en_t;            // Lane 0 is bits 7:0

    // Address map region code from address[31:28]
    typedef logic [3:0] region_t;

    // --------------------
    // Slave register types
    // --------------------
    typedef logic [`SOC_RAM_ADDR_W-1:0] ram_index_t;  // RAM word index

    typedef logic [7:0] uart_byte_t;           // One UART payload byte

    // Transmitter FSM
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

// File: src/dbus_decoder.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module dbus_decoder import soc_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    // Master side
    input  bus_addr_t  master_address_i,
    input  bus_word_t  master_wrdata_i,
    input  byte_en_t   master_byteenable_i,
    input  logic       master_read_i,
    input  logic       master_write_i,
    output bus_word_t  master_rddata_o,
    // RAM
    output ram_index_t ram_index_o,
    output logic       ram_rd_o,
    output logic       ram_wr_o,
    input  bus_word_t  ram_rddata_i,
    // GPIO
    output logic       gpio_offset_o,
    output logic       gpio_rd_o,
    output logic       gpio_wr_o,
    input  bus_word_t  gpio_rddata_i,
    // UART
    output logic       uart_offset_o,
    output logic       uart_rd_o,
    output logic       uart_wr_o,
    input  bus_word_t  uart_rddata_i,
    // Shared write path
    output bus_word_t  slave_wrdata_o,
    output byte_en_t   slave_byteenable_o
);

    region_t   region;
    logic      sel_ram, sel_gpio, sel_uart;
    region_t   rd_region_q;
    logic      rd_pending_q;
    bus_word_t rddata_mux;
    bus_word_t master_rddata_q;

    // --------------------
    // Request routing
    // --------------------
    assign region   = master_address_i[31:28];
    assign sel_ram  = (region == `SOC_REGION_RAM);
    assign sel_gpio = (region == `SOC_REGION_GPIO);
    assign sel_uart = (region == `SOC_REGION_UART);

    assign ram_rd_o  = master_read_i  & sel_ram;
    assign ram_wr_o  = master_write_i & sel_ram;
    assign gpio_rd_o = master_read_i  & sel_gpio;
    assign gpio_wr_o = master_write_i & sel_gpio;
    assign uart_rd_o = master_read_i  & sel_uart;
    assign uart_wr_o = master_write_i & sel_uart;

    assign ram_index_o        = master_address_i[`SOC_RAM_ADDR_W+1:2];  // Word index
    assign gpio_offset_o      = master_address_i[2];
    assign uart_offset_o      = master_address_i[2];
    assign slave_wrdata_o     = master_wrdata_i;
    assign slave_byteenable_o = master_byteenable_i;

    // --------------------
    // Read return
    // --------------------
    always_comb begin
        case (rd_region_q)
            `SOC_REGION_RAM:  rddata_mux = ram_rddata_i;
            `SOC_REGION_GPIO: rddata_mux = gpio_rddata_i;
            `SOC_REGION_UART: rddata_mux = uart_rddata_i;
            default:          rddata_mux = '0;   // Unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_pending_q    <= 1'b0;
            rd_region_q     <= '0;
            master_rddata_q <= '0;
        end else begin
            rd_pending_q <= master_read_i;
            if (master_read_i)
                rd_region_q <= region;
            if (rd_pending_q)
                master_rddata_q <= rddata_mux;   // Slave word is ready now
        end
    end

    assign master_rddata_o = master_rddata_q;

    a_one_slave_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({ram_rd_o, ram_wr_o, gpio_rd_o, gpio_wr_o, uart_rd_o, uart_wr_o}));

endmodule

// File: src/data_ram.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module data_ram import soc_pkg::*; (
    input  logic       clk_i,
    input  ram_index_t index_i,
    input  bus_word_t  wrdata_i,
    input  byte_en_t   byteenable_i,
    input  logic       rd_i,
    input  logic       wr_i,
    output bus_word_t  rddata_o
);

    // --------------------
    // Storage
    // --------------------
    bus_word_t mem [`SOC_RAM_DEPTH];
    bus_word_t rddata_q;

    // Byte lane writes
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteenable_i[lane])
                    mem[index_i][8*lane +: 8] <= wrdata_i[8*lane +: 8];
            end
        end
    end

    // --------------------
    // Read port
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rd_i)
            rddata_q <= mem[index_i];   // Holds until the next read
    end

    assign rddata_o = rddata_q;

endmodule

// File: src/gpio_regs.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module gpio_regs import soc_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      offset_i,
    input  bus_word_t wrdata_i,
    input  byte_en_t  byteenable_i,
    input  logic      rd_i,
    input  logic      wr_i,
    output bus_word_t rddata_o,
    output bus_word_t gpio_out_o,
    input  bus_word_t gpio_in_i
);

    bus_word_t gpio_out_q;
    bus_word_t sync_meta_q;
    bus_word_t sync_q;
    bus_word_t rddata_q;

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_out_q <= '0;
        end else if (wr_i && offset_i == `SOC_REG_OFF0) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteenable_i[lane])
                    gpio_out_q[8*lane +: 8] <= wrdata_i[8*lane +: 8];
            end
        end
    end

    // --------------------
    // Input synchronizer
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_meta_q <= '0;
            sync_q      <= '0;
        end else begin
            sync_meta_q <= gpio_in_i;
            sync_q      <= sync_meta_q;   // Two cycles behind the pins
        end
    end

    // Bus read
    always_ff @(posedge clk_i) begin
        if (rd_i)
            rddata_q <= (offset_i == `SOC_REG_OFF4) ? sync_q : gpio_out_q;
    end

    assign rddata_o   = rddata_q;
    assign gpio_out_o = gpio_out_q;

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module uart_tx import soc_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      offset_i,
    input  bus_word_t wrdata_i,
    input  logic      rd_i,
    input  logic      wr_i,
    output bus_word_t rddata_o,
    output logic      txd_o
);

    localparam int DIV_W = $clog2(`SOC_UART_DIVISOR);

    uart_state_t      state_q;
    logic [DIV_W-1:0] div_cnt_q;
    logic [2:0]       bit_cnt_q;
    uart_byte_t       shift_q;
    logic             txd_q;
    logic             bit_tick;
    logic             busy;
    bus_word_t        rddata_q;

    assign bit_tick = (div_cnt_q == DIV_W'(`SOC_UART_DIVISOR - 1));  // Last clock of a bit
    assign busy     = (state_q != UART_IDLE);

    // --------------------
    // Transmit FSM
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= UART_IDLE;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            shift_q   <= '0;
            txd_q     <= 1'b1;
        end else begin
            div_cnt_q <= (busy && !bit_tick) ? div_cnt_q + 1'b1 : '0;
            case (state_q)
                UART_IDLE: begin
                    if (wr_i && offset_i == `SOC_REG_OFF0) begin
                        shift_q <= wrdata_i[7:0];
                        txd_q   <= 1'b0;            // Start bit
                        state_q <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_tick) begin
                        txd_q     <= shift_q[0];
                        bit_cnt_q <= '0;
                        state_q   <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_tick) begin
                        if (bit_cnt_q == 3'd7) begin
                            txd_q   <= 1'b1;        // Stop bit
                            state_q <= UART_STOP;
                        end else begin
                            txd_q     <= shift_q[1];  // LSB first
                            shift_q   <= shift_q >> 1;
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_tick)
                        state_q <= UART_IDLE;
                end
                default: state_q <= UART_IDLE;
            endcase
        end
    end

    // Only the status register reads back
    always_ff @(posedge clk_i) begin
        if (rd_i)
            rddata_q <= (offset_i == `SOC_REG_OFF4) ? {31'b0, busy} : '0;
    end

    assign rddata_o = rddata_q;
    assign txd_o    = txd_q;

    a_idle_line_high: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_q == UART_IDLE) |-> txd_o);

endmodule

// File: src/soc_subsystem.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_subsystem import soc_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    // Bus master
    input  bus_addr_t master_address_i,
    input  bus_word_t master_wrdata_i,
    input  byte_en_t  master_byteenable_i,
    input  logic      master_read_i,
    input  logic      master_write_i,
    output bus_word_t master_rddata_o,
    // Pins
    output bus_word_t gpio_out_o,
    input  bus_word_t gpio_in_i,
    output logic      txd_o
);

    // --------------------
    // Decoder to slaves
    // --------------------
    bus_word_t  slave_wrdata;
    byte_en_t   slave_byteenable;

    ram_index_t ram_index;
    logic       ram_rd, ram_wr;
    bus_word_t  ram_rddata;

    logic       gpio_offset;
    logic       gpio_rd, gpio_wr;
    bus_word_t  gpio_rddata;

    logic       uart_offset;
    logic       uart_rd, uart_wr;
    bus_word_t  uart_rddata;

    dbus_decoder dbus0 (
        .clk_i               (clk_i),
        .arst_n_i            (arst_n_i),
        .master_address_i    (master_address_i),
        .master_wrdata_i     (master_wrdata_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_rddata_o     (master_rddata_o),
        .ram_index_o         (ram_index),
        .ram_rd_o            (ram_rd),
        .ram_wr_o            (ram_wr),
        .ram_rddata_i        (ram_rddata),
        .gpio_offset_o       (gpio_offset),
        .gpio_rd_o           (gpio_rd),
        .gpio_wr_o           (gpio_wr),
        .gpio_rddata_i       (gpio_rddata),
        .uart_offset_o       (uart_offset),
        .uart_rd_o           (uart_rd),
        .uart_wr_o           (uart_wr),
        .uart_rddata_i       (uart_rddata),
        .slave_wrdata_o      (slave_wrdata),
        .slave_byteenable_o  (slave_byteenable)
    );

    data_ram mainram (
        .clk_i        (clk_i),
        .index_i      (ram_index),
        .wrdata_i     (slave_wrdata),
        .byteenable_i (slave_byteenable),
        .rd_i         (ram_rd),
        .wr_i         (ram_wr),
        .rddata_o     (ram_rddata)
    );

    gpio_regs gpio_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .offset_i     (gpio_offset),
        .wrdata_i     (slave_wrdata),
        .byteenable_i (slave_byteenable),
        .rd_i         (gpio_rd),
        .wr_i         (gpio_wr),
        .rddata_o     (gpio_rddata),
        .gpio_out_o   (gpio_out_o),
        .gpio_in_i    (gpio_in_i)
    );

    uart_tx uart0 (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .offset_i (uart_offset),
        .wrdata_i (slave_wrdata),   // Takes the low byte only
        .rd_i     (uart_rd),
        .wr_i     (uart_wr),
        .rddata_o (uart_rddata),
        .txd_o    (txd_o)
    );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;          // 10 ns period
    end

    // Released on a falling edge away from the sampling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// File: tb/tb_soc_subsystem.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_soc_subsystem import soc_pkg::*; ();

    localparam int READ_CYCLES = 3;         // Strobe, return edge, sample
    localparam int BIT_CYCLES  = `SOC_UART_DIVISOR;

    logic      clk, arst_n;
    bus_addr_t address;
    bus_word_t wrdata, rddata, gpio_out, gpio_in;
    byte_en_t  byteenable;
    logic      rd, wr, txd;

    logic [31:0] lfsr = 32'he6c5;
    int          errors, tests_run, tests_failed, test_start;

    // --------------------
    // Reference model
    // --------------------
    bus_word_t  shadow_ram [`SOC_RAM_DEPTH];
    bit         touched [`SOC_RAM_DEPTH];
    ram_index_t touched_q[$];
    bus_word_t  shadow_gpio;
    uart_byte_t uart_expected_q[$];

    tb_clock_gen clkgen (.clk_o(clk), .arst_n_o(arst_n));

    soc_subsystem UUT (
        .clk_i               (clk),
        .arst_n_i            (arst_n),
        .master_address_i    (address),
        .master_wrdata_i     (wrdata),
        .master_byteenable_i (byteenable),
        .master_read_i       (rd),
        .master_write_i      (wr),
        .master_rddata_o     (rddata),
        .gpio_out_o          (gpio_out),
        .gpio_in_i           (gpio_in),
        .txd_o               (txd)
    );

    // Galois LFSR stepped once for each bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return value;
    endfunction

    function automatic bus_word_t lane_mask(input byte_en_t be);
        bus_word_t mask;
        for (int lane = 0; lane < 4; lane++)
            mask[8*lane +: 8] = {8{be[lane]}};
        return mask;
    endfunction

    function automatic bus_addr_t ram_addr(input ram_index_t idx);
        bus_addr_t addr;
        addr        = bus_addr_t'({idx, 2'b00});
        addr[31:28] = `SOC_REGION_RAM;
        return addr;
    endfunction

    function automatic bus_addr_t reg_addr(input region_t region, input logic off4);
        return {region, 25'b0, off4, 2'b00};
    endfunction

    task automatic check_value(input string name, input bus_word_t expected,
                               input bus_word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string name, input string text);
        errors++;
        $display("%s: %s", name, text);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    // --------------------
    // Bus master
    // --------------------
    task automatic bus_write(input bus_addr_t addr, input bus_word_t data, input byte_en_t be);
        @(negedge clk);
        address    = addr;
        wrdata     = data;
        byteenable = be;
        wr         = 1'b1;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_word_t data);
        @(negedge clk);
        address = addr;
        rd      = 1'b1;
        @(negedge clk);
        rd = 1'b0;
        @(negedge clk);
        data = rddata;                      // Second rising edge is behind us
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // --------------------
    // UART frame monitor
    // --------------------
    task automatic receive_frame(input string name);
        int         waited;
        uart_byte_t got;
        waited = 0;
        while (txd !== 1'b0 && waited < 4 * BIT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (txd !== 1'b0) begin
            report_failure(name, "no start bit seen on txd_o");
        end else begin
            wait_cycles(BIT_CYCLES / 2);    // Middle of the start bit
            check_value({name, " start bit"}, 32'd0, bus_word_t'(txd));
            for (int i = 0; i < 8; i++) begin
                wait_cycles(BIT_CYCLES);
                got[i] = txd;               // LSB first
            end
            wait_cycles(BIT_CYCLES);
            check_value({name, " stop bit"}, 32'd1, bus_word_t'(txd));
            if (uart_expected_q.size() == 0)
                report_failure(name, "a frame arrived while no byte was expected");
            else
                check_value(name, bus_word_t'(uart_expected_q.pop_front()), bus_word_t'(got));
        end
    endtask

    task automatic expect_line_idle(input string name, input int cycles);
        int waited;
        waited = 0;
        while (txd === 1'b1 && waited < cycles) begin
            @(negedge clk);
            waited++;
        end
        if (txd !== 1'b1)
            report_failure(name, "txd_o started a frame for a write made while busy");
    endtask

    initial begin
        bus_word_t  data, got;
        byte_en_t   be;
        ram_index_t idx;
        region_t    region;
        bus_addr_t  addrs [6];
        bus_word_t  expect_words [6];
        uart_byte_t tx_byte;
        int         waited;
        address      = '0;
        wrdata       = '0;
        byteenable   = '0;
        rd           = 1'b0;
        wr           = 1'b0;
        gpio_in      = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_start   = 0;
        shadow_gpio  = '0;
        waited = 0;
        while (arst_n !== 1'b1 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (arst_n !== 1'b1)
            report_failure("reset", "arst_n_i was never released");

        // -------------------- Reset values
        check_value("reset rddata", 32'd0, rddata);
        check_value("reset gpio_out", 32'd0, gpio_out);
        check_value("reset txd", 32'd1, bus_word_t'(txd));
        finish_test("reset");

        // -------------------- RAM
        for (int i = 0; i < 64; i++) begin
            idx = ram_index_t'(rand_bits(`SOC_RAM_ADDR_W));
            if (!touched[idx]) begin
                data = rand_bits(32);
                bus_write(ram_addr(idx), data, 4'hf);   // Known word under the lane writes
                shadow_ram[idx] = data;
                touched[idx]    = 1'b1;
                touched_q.push_back(idx);
            end
            data = rand_bits(32);
            be   = byte_en_t'(rand_bits(4));
            bus_write(ram_addr(idx), data, be);
            shadow_ram[idx] = (shadow_ram[idx] & ~lane_mask(be)) | (data & lane_mask(be));
        end
        foreach (touched_q[i]) begin
            idx = touched_q[i];
            bus_read(ram_addr(idx), got);
            check_value("ram_random", shadow_ram[idx], got);
        end
        finish_test("ram_random");

        // -------------------- Back-to-back reads
        idx  = ram_index_t'(rand_bits(`SOC_RAM_ADDR_W));
        data = rand_bits(32);
        bus_write(ram_addr(idx), data, 4'hf);
        shadow_ram[idx] = data;
        data = rand_bits(32);
        bus_write(reg_addr(`SOC_REGION_GPIO, `SOC_REG_OFF0), data, 4'hf);
        shadow_gpio = data;
        for (int i = 0; i < 6; i += 3) begin
            region            = 4'h3 + 4'(rand_bits(4) % 13);   // Regions 3 to 15 unmapped
            addrs[i]          = ram_addr(idx);
            expect_words[i]   = shadow_ram[idx];
            addrs[i+1]        = reg_addr(`SOC_REGION_GPIO, `SOC_REG_OFF0);
            expect_words[i+1] = shadow_gpio;
            addrs[i+2]        = reg_addr(region, 1'b0);
            expect_words[i+2] = '0;
        end
        for (int j = 0; j < 8; j++) begin
            @(negedge clk);
            if (j >= 2)
                check_value("back_to_back", expect_words[j-2], rddata);
            rd = (j < 6);
            if (j < 6)
                address = addrs[j];
        end
        finish_test("back_to_back");

        // -------------------- GPIO output
        for (int i = 0; i < 16; i++) begin
            data = rand_bits(32);
            be   = byte_en_t'(rand_bits(4));
            bus_write(reg_addr(`SOC_REGION_GPIO, `SOC_REG_OFF0), data, be);
            shadow_gpio = (shadow_gpio & ~lane_mask(be)) | (data & lane_mask(be));
            check_value("gpio_out pins", shadow_gpio, gpio_out);
            bus_read(reg_addr(`SOC_REGION_GPIO, `SOC_REG_OFF0), got);
            check_value("gpio_out read", shadow_gpio, got);
        end
        finish_test("gpio_out");

        // -------------------- GPIO input
        for (int i = 0; i < 4; i++) begin
            data = rand_bits(32);
            if (data == gpio_in)
                data = ~data;
            @(negedge clk);
            gpio_in = data;
            waited  = 0;
            got     = ~data;
            while (got !== data && waited + READ_CYCLES <= 10) begin
                bus_read(reg_addr(`SOC_REGION_GPIO, `SOC_REG_OFF4), got);
                waited += READ_CYCLES;
            end
            if (got !== data)
                report_failure("gpio_in", $sformatf(
                    "offset 4 did not show gpio_in_i value %h within 10 cycles", data));
        end
        finish_test("gpio_in");

        // -------------------- UART frames
        for (int i = 0; i < 3; i++) begin
            data = rand_bits(32);
            uart_expected_q.push_back(data[7:0]);
            fork
                receive_frame("uart_frame");
                bus_write(reg_addr(`SOC_REGION_UART, `SOC_REG_OFF0), data, 4'hf);
            join
            wait_cycles(BIT_CYCLES / 2 - 1);    // Rest of the stop bit
        end
        finish_test("uart_frame");

        // -------------------- UART busy
        data    = rand_bits(32);
        tx_byte = data[7:0] ^ 8'hff;            // Differs from the accepted byte
        uart_expected_q.push_back(data[7:0]);
        fork
            receive_frame("uart_busy");
            begin
                bus_write(reg_addr(`SOC_REGION_UART, `SOC_REG_OFF0), data, 4'hf);
                bus_read(reg_addr(`SOC_REGION_UART, `SOC_REG_OFF4), got);
                check_value("uart_busy set", 32'd1, got);
                wait_cycles(2 * BIT_CYCLES);
                bus_write(reg_addr(`SOC_REGION_UART, `SOC_REG_OFF0), bus_word_t'(tx_byte), 4'hf);
            end
        join
        wait_cycles(BIT_CYCLES / 2 - 1);
        bus_read(reg_addr(`SOC_REGION_UART, `SOC_REG_OFF4), got);
        check_value("uart_busy clear", 32'd0, got);
        expect_line_idle("uart_busy", 12 * BIT_CYCLES);
        finish_test("uart_busy");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/soc_pkg.sv
src/dbus_decoder.sv
src/data_ram.sv
src/gpio_regs.sv
src/uart_tx.sv
src/soc_subsystem.sv
tb/tb_clock_gen.sv
tb/tb_soc_subsystem.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, status follows the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --assert -f vlog.f --top-module tb_soc_subsystem \
    && ./obj_dir/Vtb_soc_subsystem | tee /dev/stderr | grep -q "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
